/* project.f */
rtl/pcs_err_pkg.sv
rtl/err_csr.sv
rtl/block_classifier.sv
rtl/burst_scheduler.sv
rtl/block_corruptor.sv
rtl/pcs_err_inject.sv
test/tb_pcs_err_inject.sv

/* rtl/block_classifier.sv */
`timescale 1ns/1ps

module block_classifier
(
        input  pcs_err_pkg::block_beat_t        i_beat,
        input  pcs_err_pkg::err_cfg_t           i_cfg,
        output logic                            o_match,
        output pcs_err_pkg::coded_block_t       o_bad_block
);

logic sh_data;
logic sh_ctrl;

// header decode, 00 and 11 are invalid and match neither
assign sh_data = (i_beat.block.sh == pcs_err_pkg::SH_DATA);
assign sh_ctrl = (i_beat.block.sh == pcs_err_pkg::SH_CTRL);

// block type vs mode
always_comb
begin
        case (i_cfg.mode)
        pcs_err_pkg::MODE_ALIGNER : o_match = i_beat.tag;
        pcs_err_pkg::MODE_CTRL    : o_match = sh_ctrl;
        pcs_err_pkg::MODE_DATA    : o_match = sh_data;
        pcs_err_pkg::MODE_ALL     : o_match = 1'b1;
        default                   : o_match = 1'b0;     // off and unused codes
        endcase
end

// header untouched, masked payload bits flipped
assign o_bad_block.sh      = i_beat.block.sh;
assign o_bad_block.payload = i_beat.block.payload ^ i_cfg.mask;

endmodule

/* rtl/block_corruptor.sv */
`timescale 1ns/1ps

module block_corruptor
(
        input  logic                            i_clock,
        input  logic                            i_reset,
        input  pcs_err_pkg::block_beat_t        i_beat,
        input  pcs_err_pkg::coded_block_t       i_bad_block,
        input  logic                            i_hit,
        input  logic                            i_update,
        output pcs_err_pkg::block_beat_t        o_beat,
        output logic [31:0]                     o_hit_count
);

logic                           valid_q;
logic                           tag_q;
pcs_err_pkg::coded_block_t      block_q;

// outgoing valid flag
always_ff @(posedge i_clock)
begin
        if (i_reset)
                valid_q <= 1'b0;
        else
                valid_q <= i_beat.valid;
end

// tag and block delayed by one cycle
always_ff @(posedge i_clock)
begin
        tag_q   <= i_beat.tag;
        block_q <= i_hit ? i_bad_block : i_beat.block;  // swap in corrupted block
end

assign o_beat.valid = valid_q;
assign o_beat.tag   = tag_q;
assign o_beat.block = block_q;

// corrupted block counter
always_ff @(posedge i_clock)
begin
        if (i_reset)
                o_hit_count <= '0;
        else if (i_update)
                o_hit_count <= '0;      // new run starts from zero
        else if (i_hit)
                o_hit_count <= o_hit_count + 32'd1;
end

endmodule

/* rtl/burst_scheduler.sv */
`timescale 1ns/1ps

module burst_scheduler
#(
        parameter int MAX_ERR_BURST  = 1024,
        parameter int MAX_ERR_PERIOD = 1024,
        parameter int MAX_ERR_REPEAT = 16
)
(
        input  logic                    i_clock,
        input  logic                    i_reset,
        input  logic                    i_valid,
        input  logic                    i_match,
        input  logic                    i_update,
        input  pcs_err_pkg::err_cfg_t   i_cfg,
        output logic                    o_hit
);

// wide enough to hold the max value itself
localparam int NB_BURST_CNT  = $clog2(MAX_ERR_BURST + 1);
localparam int NB_PERIOD_CNT = $clog2(MAX_ERR_PERIOD + 1);
localparam int NB_REPEAT_CNT = $clog2(MAX_ERR_REPEAT + 1);

logic [NB_BURST_CNT-1:0]  burst_cnt;    // hits left this period
logic [NB_PERIOD_CNT-1:0] period_cnt;   // blocks left this period
logic [NB_REPEAT_CNT-1:0] repeat_cnt;   // periods left

logic burst_on;
logic active;
logic period_end;

assign burst_on   = (burst_cnt != '0);
assign active     = (period_cnt != '0) && (repeat_cnt != '0);
assign period_end = (period_cnt == NB_PERIOD_CNT'(1));     // last block of period

// the one and only corruption decision
assign o_hit = i_valid && i_match && burst_on && active && !i_update;

always_ff @(posedge i_clock)
begin
        if (i_reset)
        begin
                burst_cnt  <= '0;
                period_cnt <= '0;
                repeat_cnt <= '0;
        end
        else if (i_update)
        begin
                burst_cnt  <= NB_BURST_CNT'(i_cfg.burst);
                period_cnt <= NB_PERIOD_CNT'(i_cfg.period);
                // zero period kills the whole run
                repeat_cnt <= (i_cfg.period == '0) ? '0 : NB_REPEAT_CNT'(i_cfg.repeats);
        end
        else if (i_valid && active)
        begin
                if (period_end)
                begin
                        repeat_cnt <= repeat_cnt - 1'b1;
                        if (repeat_cnt > NB_REPEAT_CNT'(1))
                        begin
                                // next period starts right away
                                burst_cnt  <= NB_BURST_CNT'(i_cfg.burst);
                                period_cnt <= NB_PERIOD_CNT'(i_cfg.period);
                        end
                        else
                        begin
                                burst_cnt  <= '0;       // run finished
                                period_cnt <= '0;
                        end
                end
                else
                begin
                        period_cnt <= period_cnt - 1'b1;        // every valid block
                        if (o_hit)
                                burst_cnt <= burst_cnt - 1'b1;  // matching ones only
                end
        end
end

endmodule

/* rtl/err_csr.sv */
`timescale 1ns/1ps

module err_csr
#(
        parameter int MAX_ERR_BURST  = 1024,
        parameter int MAX_ERR_PERIOD = 1024,
        parameter int MAX_ERR_REPEAT = 16
)
(
        input  logic                    i_clock,
        input  logic                    i_reset,
        // write address / data / response
        input  logic [7:0]              i_awaddr,
        input  logic                    i_awvalid,
        output logic                    o_awready,
        input  logic [31:0]             i_wdata,
        input  logic [3:0]              i_wstrb,
        input  logic                    i_wvalid,
        output logic                    o_wready,
        output logic [1:0]              o_bresp,
        output logic                    o_bvalid,
        input  logic                    i_bready,
        // read address / data
        input  logic [7:0]              i_araddr,
        input  logic                    i_arvalid,
        output logic                    o_arready,
        output logic [31:0]             o_rdata,
        output logic [1:0]              o_rresp,
        output logic                    o_rvalid,
        input  logic                    i_rready,
        // datapath side
        input  logic [31:0]             i_hit_count,
        output pcs_err_pkg::err_cfg_t   o_cfg,
        output logic                    o_update
);

localparam logic [1:0] RESP_OKAY = 2'b00;

// staged copies, what software sees
pcs_err_pkg::inj_mode_e stg_mode;
logic [31:0]            stg_mask_lo;
logic [31:0]            stg_mask_hi;
logic [31:0]            stg_burst;
logic [31:0]            stg_period;
logic [31:0]            stg_repeat;

logic                   wr_en;
logic                   rd_en;
logic                   do_update;
pcs_err_pkg::inj_mode_e next_mode;

// byte lane merge
function automatic logic [31:0] merge_strb(input logic [31:0] old_val,
                                           input logic [31:0] new_val,
                                           input logic [3:0]  strb);
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++)
        begin
                if (strb[b])
                        res[8*b +: 8] = new_val[8*b +: 8];
        end
        return res;
endfunction

// saturate staged value to the hw limit
function automatic logic [15:0] clamp16(input logic [31:0] value, input int unsigned limit);
        logic [31:0] lim;
        lim = limit;
        if (value > lim)
                return lim[15:0];
        return value[15:0];
endfunction

assign wr_en     = o_awready && i_awvalid && i_wvalid;     // accept cycle
assign rd_en     = o_arready && i_arvalid;
assign do_update = wr_en && (i_awaddr == pcs_err_pkg::REG_CTRL) && i_wstrb[3]
                   && i_wdata[pcs_err_pkg::CTRL_UPDATE_BIT];
// mode written in the same beat wins
assign next_mode = i_wstrb[0] ? pcs_err_pkg::inj_mode_e'(i_wdata[2:0]) : stg_mode;

assign o_wready = o_awready;    // aw and w always taken together
assign o_bresp  = RESP_OKAY;
assign o_rresp  = RESP_OKAY;

// write side
always_ff @(posedge i_clock)
begin
        if (i_reset)
        begin
                o_awready   <= 1'b0;
                o_bvalid    <= 1'b0;
                o_update    <= 1'b0;
                o_cfg       <= '0;              // MODE_OFF
                stg_mode    <= pcs_err_pkg::MODE_OFF;
                stg_mask_lo <= '0;
                stg_mask_hi <= '0;
                stg_burst   <= '0;
                stg_period  <= '0;
                stg_repeat  <= '0;
        end
        else
        begin
                o_awready <= i_awvalid && i_wvalid && !o_awready && !o_bvalid;
                o_update  <= do_update;         // one cycle pulse
                if (wr_en)
                begin
                        o_bvalid <= 1'b1;
                        case (i_awaddr)
                        pcs_err_pkg::REG_CTRL    : stg_mode    <= next_mode;
                        pcs_err_pkg::REG_MASK_LO : stg_mask_lo <= merge_strb(stg_mask_lo, i_wdata, i_wstrb);
                        pcs_err_pkg::REG_MASK_HI : stg_mask_hi <= merge_strb(stg_mask_hi, i_wdata, i_wstrb);
                        pcs_err_pkg::REG_BURST   : stg_burst   <= merge_strb(stg_burst, i_wdata, i_wstrb);
                        pcs_err_pkg::REG_PERIOD  : stg_period  <= merge_strb(stg_period, i_wdata, i_wstrb);
                        pcs_err_pkg::REG_REPEAT  : stg_repeat  <= merge_strb(stg_repeat, i_wdata, i_wstrb);
                        default                  : ;   // hit count is read only
                        endcase
                end
                else if (i_bready)
                        o_bvalid <= 1'b0;
                if (do_update)
                begin
                        // cfg is live during the update pulse
                        o_cfg.mode    <= next_mode;
                        o_cfg.mask    <= {stg_mask_hi, stg_mask_lo};
                        o_cfg.burst   <= clamp16(stg_burst, MAX_ERR_BURST);
                        o_cfg.period  <= clamp16(stg_period, MAX_ERR_PERIOD);
                        o_cfg.repeats <= clamp16(stg_repeat, MAX_ERR_REPEAT);
                end
        end
end

// read side
always_ff @(posedge i_clock)
begin
        if (i_reset)
        begin
                o_arready <= 1'b0;
                o_rvalid  <= 1'b0;
                o_rdata   <= '0;
        end
        else
        begin
                o_arready <= i_arvalid && !o_arready && !o_rvalid;
                if (rd_en)
                begin
                        o_rvalid <= 1'b1;
                        case (i_araddr)
                        pcs_err_pkg::REG_CTRL      : o_rdata <= {29'd0, stg_mode};
                        pcs_err_pkg::REG_MASK_LO   : o_rdata <= stg_mask_lo;
                        pcs_err_pkg::REG_MASK_HI   : o_rdata <= stg_mask_hi;
                        pcs_err_pkg::REG_BURST     : o_rdata <= stg_burst;
                        pcs_err_pkg::REG_PERIOD    : o_rdata <= stg_period;
                        pcs_err_pkg::REG_REPEAT    : o_rdata <= stg_repeat;
                        pcs_err_pkg::REG_HIT_COUNT : o_rdata <= i_hit_count;   // live value
                        default                    : o_rdata <= '0;
                        endcase
                end
                else if (i_rready)
                        o_rvalid <= 1'b0;
        end
end

endmodule

/* rtl/pcs_err_inject.sv */
`timescale 1ns/1ps

module pcs_err_inject
#(
        parameter int MAX_ERR_BURST  = 1024,
        parameter int MAX_ERR_PERIOD = 1024,
        parameter int MAX_ERR_REPEAT = 16
)
(
        input  logic                            i_clock,
        input  logic                            i_reset,
        // axi4-lite config port
        input  logic [7:0]                      i_awaddr,
        input  logic                            i_awvalid,
        output logic                            o_awready,
        input  logic [31:0]                     i_wdata,
        input  logic [3:0]                      i_wstrb,
        input  logic                            i_wvalid,
        output logic                            o_wready,
        output logic [1:0]                      o_bresp,
        output logic                            o_bvalid,
        input  logic                            i_bready,
        input  logic [7:0]                      i_araddr,
        input  logic                            i_arvalid,
        output logic                            o_arready,
        output logic [31:0]                     o_rdata,
        output logic [1:0]                      o_rresp,
        output logic                            o_rvalid,
        input  logic                            i_rready,
        // block stream
        input  pcs_err_pkg::block_beat_t        i_beat,
        output pcs_err_pkg::block_beat_t        o_beat
);

pcs_err_pkg::err_cfg_t          cfg;
logic                           update;
logic [31:0]                    hit_count;
logic                           match;
pcs_err_pkg::coded_block_t      bad_block;
logic                           hit;

err_csr
#(
        .MAX_ERR_BURST  (MAX_ERR_BURST),
        .MAX_ERR_PERIOD (MAX_ERR_PERIOD),
        .MAX_ERR_REPEAT (MAX_ERR_REPEAT)
)
u_err_csr
(
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_awaddr       (i_awaddr),
        .i_awvalid      (i_awvalid),
        .o_awready      (o_awready),
        .i_wdata        (i_wdata),
        .i_wstrb        (i_wstrb),
        .i_wvalid       (i_wvalid),
        .o_wready       (o_wready),
        .o_bresp        (o_bresp),
        .o_bvalid       (o_bvalid),
        .i_bready       (i_bready),
        .i_araddr       (i_araddr),
        .i_arvalid      (i_arvalid),
        .o_arready      (o_arready),
        .o_rdata        (o_rdata),
        .o_rresp        (o_rresp),
        .o_rvalid       (o_rvalid),
        .i_rready       (i_rready),
        .i_hit_count    (hit_count),
        .o_cfg          (cfg),
        .o_update       (update)
);

// type match and flipped payload, no clock
block_classifier u_block_classifier
(
        .i_beat         (i_beat),
        .i_cfg          (cfg),
        .o_match        (match),
        .o_bad_block    (bad_block)
);

burst_scheduler
#(
        .MAX_ERR_BURST  (MAX_ERR_BURST),
        .MAX_ERR_PERIOD (MAX_ERR_PERIOD),
        .MAX_ERR_REPEAT (MAX_ERR_REPEAT)
)
u_burst_scheduler
(
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_valid        (i_beat.valid),
        .i_match        (match),
        .i_update       (update),
        .i_cfg          (cfg),
        .o_hit          (hit)
);

block_corruptor u_block_corruptor
(
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_beat         (i_beat),
        .i_bad_block    (bad_block),
        .i_hit          (hit),
        .i_update       (update),
        .o_beat         (o_beat),
        .o_hit_count    (hit_count)
);

endmodule

/* rtl/pcs_err_pkg.sv */
package pcs_err_pkg;

        // what kind of block gets hit
        typedef enum logic [2:0]
        {
                MODE_OFF     = 3'd0,    // pass everything
                MODE_ALIGNER = 3'd1,    // aligner tagged blocks only
                MODE_CTRL    = 3'd2,    // sync header 10
                MODE_DATA    = 3'd3,    // sync header 01
                MODE_ALL     = 3'd4     // every block
        } inj_mode_e;

        // sync header codes
        localparam logic [1:0] SH_DATA = 2'b01;
        localparam logic [1:0] SH_CTRL = 2'b10;

        // 66 bit coded block, header on top
        typedef struct packed
        {
                logic [1:0]  sh;
                logic [63:0] payload;
        } coded_block_t;

        // one beat of the block stream
        typedef struct packed
        {
                logic         valid;
                logic         tag;      // aligner marker from upstream
                coded_block_t block;
        } block_beat_t;

        // active injection settings
        typedef struct packed
        {
                inj_mode_e   mode;
                logic [63:0] mask;      // ones get flipped
                logic [15:0] burst;     // hits per period
                logic [15:0] period;    // valid blocks per period
                logic [15:0] repeats;   // number of periods
        } err_cfg_t;

        // axi byte offsets
        localparam logic [7:0] REG_CTRL      = 8'h00;
        localparam logic [7:0] REG_MASK_LO   = 8'h04;
        localparam logic [7:0] REG_MASK_HI   = 8'h08;
        localparam logic [7:0] REG_BURST     = 8'h0C;
        localparam logic [7:0] REG_PERIOD    = 8'h10;
        localparam logic [7:0] REG_REPEAT    = 8'h14;
        localparam logic [7:0] REG_HIT_COUNT = 8'h18;

        localparam int CTRL_UPDATE_BIT = 31;    // self clearing, mode in 2:0

endpackage

/* test/tb_pcs_err_inject.sv */
`timescale 1ns/1ps

module tb_pcs_err_inject;

localparam int CLK_PERIOD   = 4;
localparam int NUM_ROWS     = 7;
localparam int HS_LIMIT     = 16;       // cycles allowed for one handshake
localparam int AXI_OVERHEAD = 80;       // register traffic per row in cycles

// one row of the test table
typedef struct packed
{
        pcs_err_pkg::inj_mode_e mode;
        logic [63:0]            mask;
        logic [15:0]            burst;
        logic [15:0]            period;
        logic [15:0]            repeats;
        logic [15:0]            nblocks;
        logic [7:0]             sh_pat;         // set bit k%8 gives a control header
        logic [7:0]             tag_pat;        // set bit k%8 gives an aligner tag
        logic [7:0]             gap_pat;        // set bit k%8 drops valid
        logic [15:0]            exp_hits;       // worked out by hand
} test_row_t;

logic                           i_clock = 1'b0;
logic                           i_reset;
logic [7:0]                     i_awaddr;
logic                           i_awvalid;
logic                           o_awready;
logic [31:0]                    i_wdata;
logic [3:0]                     i_wstrb;
logic                           i_wvalid;
logic                           o_wready;
logic [1:0]                     o_bresp;
logic                           o_bvalid;
logic                           i_bready;
logic [7:0]                     i_araddr;
logic                           i_arvalid;
logic                           o_arready;
logic [31:0]                    o_rdata;
logic [1:0]                     o_rresp;
logic                           o_rvalid;
logic                           i_rready;
pcs_err_pkg::block_beat_t       i_beat;
pcs_err_pkg::block_beat_t       o_beat;

test_row_t                      rows [NUM_ROWS];
string                          row_names [NUM_ROWS];
int                             row_cnt = 0;
bit                             table_ready = 1'b0;
int                             errors = 0;
logic [15:0]                    lfsr = 16'd6;   // payload source
pcs_err_pkg::block_beat_t       exp_q [$];      // beats waiting for o_beat
int                             m_burst;        // hits left in the model period
int                             m_period;       // blocks left in the model period
int                             m_repeat;       // periods left in the model

pcs_err_inject uut
(
        .i_clock (i_clock), .i_reset (i_reset),
        .i_awaddr (i_awaddr), .i_awvalid (i_awvalid), .o_awready (o_awready),
        .i_wdata (i_wdata), .i_wstrb (i_wstrb), .i_wvalid (i_wvalid), .o_wready (o_wready),
        .o_bresp (o_bresp), .o_bvalid (o_bvalid), .i_bready (i_bready),
        .i_araddr (i_araddr), .i_arvalid (i_arvalid), .o_arready (o_arready),
        .o_rdata (o_rdata), .o_rresp (o_rresp), .o_rvalid (o_rvalid), .i_rready (i_rready),
        .i_beat (i_beat), .o_beat (o_beat)
);

always #(CLK_PERIOD / 2) i_clock = ~i_clock;

// fibonacci lfsr with taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

task automatic add_row(input string name, input pcs_err_pkg::inj_mode_e mode,
                       input logic [63:0] mask, input int burst, input int period,
                       input int repeats, input int nblocks, input logic [7:0] sh_pat,
                       input logic [7:0] tag_pat, input logic [7:0] gap_pat,
                       input int exp_hits);
        row_names[row_cnt]       = name;
        rows[row_cnt].mode       = mode;
        rows[row_cnt].mask       = mask;
        rows[row_cnt].burst      = 16'(burst);
        rows[row_cnt].period     = 16'(period);
        rows[row_cnt].repeats    = 16'(repeats);
        rows[row_cnt].nblocks    = 16'(nblocks);
        rows[row_cnt].sh_pat     = sh_pat;
        rows[row_cnt].tag_pat    = tag_pat;
        rows[row_cnt].gap_pat    = gap_pat;
        rows[row_cnt].exp_hits   = 16'(exp_hits);
        row_cnt++;
endtask

task automatic load_table();
        //      name           mode                      mask                   burst per rep  n
        //      sh     tag    gap    hits
        add_row("off_pass",    pcs_err_pkg::MODE_OFF,     64'hFFFF_FFFF_FFFF_FFFF, 3, 8, 2, 16,
                8'hA5, 8'h11, 8'h00, 0);
        add_row("all_burst",   pcs_err_pkg::MODE_ALL,     64'hF0F0_0000_1234_00FF, 3, 8, 2, 24,
                8'h0F, 8'h00, 8'h00, 6);
        add_row("ctrl_mixed",  pcs_err_pkg::MODE_CTRL,    64'h8000_0000_0000_0001, 2, 6, 3, 24,
                8'h69, 8'h00, 8'h00, 6);
        add_row("data_mixed",  pcs_err_pkg::MODE_DATA,    64'h0000_FFFF_0000_FFFF, 2, 5, 2, 16,
                8'h96, 8'h00, 8'h00, 4);
        add_row("aligner",     pcs_err_pkg::MODE_ALIGNER, 64'h5555_5555_AAAA_AAAA, 1, 4, 4, 20,
                8'h3C, 8'h22, 8'h00, 4);
        add_row("valid_gaps",  pcs_err_pkg::MODE_ALL,     64'h0123_4567_89AB_CDEF, 2, 4, 3, 24,
                8'h5A, 8'h00, 8'h24, 6);
        add_row("zero_period", pcs_err_pkg::MODE_ALL,     64'hFFFF_0000_FFFF_0000, 2, 0, 2, 12,
                8'hF0, 8'h00, 8'h00, 0);
endtask

task automatic check_value(input string what, input logic [67:0] exp, input logic [67:0] act);
        assert (act === exp)
        else
        begin
                errors++;
                $display("Error %s: expected %h, actual %h", what, exp, act);
        end
endtask

task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        int n;
        @(posedge i_clock);
        i_awaddr  <= addr;
        i_wdata   <= data;
        i_wstrb   <= 4'hF;
        i_awvalid <= 1'b1;
        i_wvalid  <= 1'b1;
        i_bready  <= 1'b1;
        n = 0;
        do
        begin
                @(negedge i_clock);
                n++;
        end
        while (!o_awready && n < HS_LIMIT);
        assert (o_awready && o_wready)
        else
        begin
                errors++;
                $display("AXI write to %h was never accepted", addr);
        end
        @(posedge i_clock);     // address and data taken on this edge
        i_awvalid <= 1'b0;
        i_wvalid  <= 1'b0;
        n = 0;
        do
        begin
                @(negedge i_clock);
                n++;
        end
        while (!o_bvalid && n < HS_LIMIT);
        assert (o_bvalid && o_bresp == 2'b00)
        else
        begin
                errors++;
                $display("AXI write to %h got no OKAY response", addr);
        end
        @(posedge i_clock);
        i_bready <= 1'b0;
endtask

task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
        int n;
        @(posedge i_clock);
        i_araddr  <= addr;
        i_arvalid <= 1'b1;
        i_rready  <= 1'b1;
        n = 0;
        do
        begin
                @(negedge i_clock);
                n++;
        end
        while (!o_arready && n < HS_LIMIT);
        assert (o_arready)
        else
        begin
                errors++;
                $display("AXI read of %h was never accepted", addr);
        end
        @(posedge i_clock);
        i_arvalid <= 1'b0;
        n = 0;
        do
        begin
                @(negedge i_clock);
                n++;
        end
        while (!o_rvalid && n < HS_LIMIT);
        assert (o_rvalid && o_rresp == 2'b00)
        else
        begin
                errors++;
                $display("AXI read of %h got no OKAY data response", addr);
        end
        data = o_rdata;
        @(posedge i_clock);
        i_rready <= 1'b0;
endtask

task automatic check_reg(input string what, input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rdata;
        axi_read(addr, rdata);
        check_value(what, 68'(exp), 68'(rdata));
endtask

// reference model of the injection rule for one beat
task automatic predict_hit(input pcs_err_pkg::block_beat_t beat, input test_row_t row,
                           output logic hit);
        logic match;
        logic active;
        case (row.mode)
        pcs_err_pkg::MODE_ALIGNER : match = beat.tag;
        pcs_err_pkg::MODE_CTRL    : match = (beat.block.sh == pcs_err_pkg::SH_CTRL);
        pcs_err_pkg::MODE_DATA    : match = (beat.block.sh == pcs_err_pkg::SH_DATA);
        pcs_err_pkg::MODE_ALL     : match = 1'b1;
        default                   : match = 1'b0;
        endcase
        active = (m_period != 0) && (m_repeat != 0);
        hit    = beat.valid && match && (m_burst != 0) && active;
        if (beat.valid && active)
        begin
                if (hit)
                        m_burst--;
                m_period--;     // every valid block
                if (m_period == 0)
                begin
                        m_repeat--;
                        if (m_repeat != 0)
                        begin
                                m_burst  = row.burst;   // next period
                                m_period = row.period;
                        end
                end
        end
endtask

task automatic run_row(input int r);
        test_row_t                row;
        string                    name;
        pcs_err_pkg::block_beat_t beat;
        pcs_err_pkg::block_beat_t exp;
        logic                     hit;
        int                       hits;
        row  = rows[r];
        name = row_names[r];
        hits = 0;
        axi_write(pcs_err_pkg::REG_MASK_LO, row.mask[31:0]);
        axi_write(pcs_err_pkg::REG_MASK_HI, row.mask[63:32]);
        axi_write(pcs_err_pkg::REG_BURST, 32'(row.burst));
        axi_write(pcs_err_pkg::REG_PERIOD, 32'(row.period));
        axi_write(pcs_err_pkg::REG_REPEAT, 32'(row.repeats));
        axi_write(pcs_err_pkg::REG_CTRL, {1'b1, 28'd0, row.mode});     // update bit
        repeat (2) @(posedge i_clock);
        check_reg({name, " hit_count after update"}, pcs_err_pkg::REG_HIT_COUNT, 32'd0);
        check_reg({name, " ctrl"}, pcs_err_pkg::REG_CTRL, {29'd0, row.mode});
        check_reg({name, " mask_lo"}, pcs_err_pkg::REG_MASK_LO, row.mask[31:0]);
        check_reg({name, " mask_hi"}, pcs_err_pkg::REG_MASK_HI, row.mask[63:32]);
        check_reg({name, " burst"}, pcs_err_pkg::REG_BURST, 32'(row.burst));
        check_reg({name, " period"}, pcs_err_pkg::REG_PERIOD, 32'(row.period));
        check_reg({name, " repeat"}, pcs_err_pkg::REG_REPEAT, 32'(row.repeats));
        m_burst  = row.burst;           // model sees the update
        m_period = row.period;
        m_repeat = row.repeats;
        // one extra pass flushes the last beat
        for (int k = 0; k <= row.nblocks; k++)
        begin
                @(posedge i_clock);
                if (k < row.nblocks)
                begin
                        beat.valid    = !row.gap_pat[k % 8];
                        beat.tag      = row.tag_pat[k % 8];
                        beat.block.sh = row.sh_pat[k % 8] ? pcs_err_pkg::SH_CTRL
                                                          : pcs_err_pkg::SH_DATA;
                        for (int b = 0; b < 64; b++)
                        begin
                                beat.block.payload[b] = lfsr[15];
                                lfsr = lfsr_next(lfsr);
                        end
                        predict_hit(beat, row, hit);
                        exp = beat;
                        if (hit)
                        begin
                                exp.block.payload = beat.block.payload ^ row.mask;
                                hits++;
                        end
                        exp_q.push_back(exp);
                        i_beat <= beat;
                end
                else
                        i_beat <= '0;
                @(negedge i_clock);
                if (k > 0)
                        check_value({name, " o_beat"}, exp_q.pop_front(), o_beat);
        end
        check_value({name, " model hits"}, 68'(row.exp_hits), 68'(hits));
        check_reg({name, " hit_count"}, pcs_err_pkg::REG_HIT_COUNT, 32'(hits));
endtask

// watchdog sized from the table
initial
begin
        int total;
        wait (table_ready);
        total = 20;
        for (int r = 0; r < row_cnt; r++)
                total += rows[r].nblocks + AXI_OVERHEAD;
        #(2 * total * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", 2 * total);
        $display("Verification failed");
        $finish;
end

initial
begin
        i_reset   <= 1'b1;
        i_awaddr  <= '0;
        i_awvalid <= 1'b0;
        i_wdata   <= '0;
        i_wstrb   <= '0;
        i_wvalid  <= 1'b0;
        i_bready  <= 1'b0;
        i_araddr  <= '0;
        i_arvalid <= 1'b0;
        i_rready  <= 1'b0;
        i_beat    <= '0;
        load_table();
        table_ready = 1'b1;
        repeat (4) @(posedge i_clock);
        i_reset <= 1'b0;
        @(negedge i_clock);
        check_value("reset o_beat.valid", 68'd0, 68'(o_beat.valid));
        check_reg("reset hit_count", pcs_err_pkg::REG_HIT_COUNT, 32'd0);
        for (int r = 0; r < row_cnt; r++)
                run_row(r);
        $display("Done: %0d tests, %0d errors", row_cnt, errors);
        if (errors == 0)
                $display("Verification passed");
        else
                $display("Verification failed");
        $finish;
end

endmodule
